// ==== rtl/csr_macros.svh ====
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// CSR numbers
`define CSR_ADDR_CRMD    14'h000
`define CSR_ADDR_PRMD    14'h001
`define CSR_ADDR_ESTAT   14'h005
`define CSR_ADDR_ERA     14'h006
`define CSR_ADDR_EENTRY  14'h00c
`define CSR_ADDR_SAVE0   14'h030
`define CSR_ADDR_SAVE1   14'h031
`define CSR_ADDR_SAVE2   14'h032
`define CSR_ADDR_SAVE3   14'h033
`define CSR_ADDR_TID     14'h040
`define CSR_ADDR_TCFG    14'h041
`define CSR_ADDR_TVAL    14'h042
`define CSR_ADDR_TICLR   14'h044

// rdcnt selector
`define RDCNT_NONE   2'd0
`define RDCNT_ID     2'd1
`define RDCNT_VLOW   2'd2
`define RDCNT_VHIGH  2'd3

// bit positions in csr_sel_t, regfile entries first
`define CSR_SEL_CRMD    0
`define CSR_SEL_PRMD    1
`define CSR_SEL_ESTAT   2
`define CSR_SEL_ERA     3
`define CSR_SEL_EENTRY  4
`define CSR_SEL_SAVE0   5
`define CSR_SEL_SAVE1   6
`define CSR_SEL_SAVE2   7
`define CSR_SEL_SAVE3   8
`define CSR_SEL_TID     9
`define CSR_SEL_TCFG    10
`define CSR_SEL_TICLR   11
`define CSR_RF_NUM      10

// software writable bits
`define CSR_CRMD_WMASK    32'h0000_01ff
`define CSR_PRMD_WMASK    32'h0000_0007
`define CSR_ESTAT_WMASK   32'h0000_0003
`define CSR_EENTRY_WMASK  32'hffff_ffc0
`define CSR_FULL_WMASK    32'hffff_ffff
`define CSR_TICLR_WMASK   32'h0000_0001

// reset values, DA set in CRMD
`define CSR_CRMD_RST  32'h0000_0008
`define CSR_ZERO_RST  32'h0000_0000

// field positions
`define CSR_TCFG_EN        0
`define CSR_TCFG_PERIODIC  1
`define CSR_TCFG_INITVAL   31:2
`define CSR_TICLR_CLR      0
`define CSR_ESTAT_TI       11
`define CSR_ESTAT_HWI      9:2

`endif

// ==== rtl/csr_pkg.sv ====
package csr_pkg;

  // CSR data word
  typedef logic [31:0] csr_data_t;

  // CSR number as carried by csrrd/csrwr/csrxchg
  typedef logic [13:0] csr_addr_t;

  // per-bit write enable, 1 takes the new data
  typedef logic [31:0] csr_mask_t;

  // 0 normal read, 1 counter id, 2 low word, 3 high word
  typedef logic [1:0] rdcnt_t;

  // one-hot select over the writable CSRs
  typedef logic [11:0] csr_sel_t;

  // free-running stable counter
  typedef logic [63:0] cnt64_t;

  // hardware interrupt lines
  typedef logic [7:0] irq_t;

  // masked merge of a write into a stored value
  function automatic csr_data_t csr_merge(
    input csr_data_t old_val,
    input csr_data_t new_val,
    input csr_mask_t wr_mask,
    input csr_mask_t writable
  );
    csr_mask_t eff_mask;
    eff_mask = wr_mask & writable;
    return (old_val & ~eff_mask) | (new_val & eff_mask);
  endfunction

endpackage

// ==== rtl/csr_wr_if.sv ====
`timescale 1ns/100ps

interface csr_wr_if;
  import csr_pkg::*;

  // one pulse per accepted write
  logic      wr_valid;
  csr_sel_t  sel;
  csr_mask_t mask;
  csr_data_t data;

  modport src (
    output wr_valid,
    output sel,
    output mask,
    output data
  );

  modport sink (
    input wr_valid,
    input sel,
    input mask,
    input data
  );

endinterface

// ==== rtl/csr_write_stage.sv ====
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_write_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid_i,
  input  logic               commit_i,
  input  logic               m2_stall_i,
  input  logic               csr_we_i,
  input  csr_pkg::csr_addr_t csr_w_addr_i,
  input  csr_pkg::csr_mask_t csr_w_mask_i,
  input  csr_pkg::csr_data_t csr_w_data_i,
  csr_wr_if.src              wr
);
  import csr_pkg::*;

  logic     wr_ok;
  csr_sel_t sel_d;

  // only committed, unstalled M2 writes
  assign wr_ok = valid_i && commit_i && csr_we_i && !m2_stall_i;

  always_comb begin
    sel_d = '0;
    case (csr_w_addr_i)
      `CSR_ADDR_CRMD:   sel_d[`CSR_SEL_CRMD]   = 1'b1;
      `CSR_ADDR_PRMD:   sel_d[`CSR_SEL_PRMD]   = 1'b1;
      `CSR_ADDR_ESTAT:  sel_d[`CSR_SEL_ESTAT]  = 1'b1;
      `CSR_ADDR_ERA:    sel_d[`CSR_SEL_ERA]    = 1'b1;
      `CSR_ADDR_EENTRY: sel_d[`CSR_SEL_EENTRY] = 1'b1;
      `CSR_ADDR_SAVE0:  sel_d[`CSR_SEL_SAVE0]  = 1'b1;
      `CSR_ADDR_SAVE1:  sel_d[`CSR_SEL_SAVE1]  = 1'b1;
      `CSR_ADDR_SAVE2:  sel_d[`CSR_SEL_SAVE2]  = 1'b1;
      `CSR_ADDR_SAVE3:  sel_d[`CSR_SEL_SAVE3]  = 1'b1;
      `CSR_ADDR_TID:    sel_d[`CSR_SEL_TID]    = 1'b1;
      `CSR_ADDR_TCFG:   sel_d[`CSR_SEL_TCFG]   = 1'b1;
      `CSR_ADDR_TICLR:  sel_d[`CSR_SEL_TICLR]  = 1'b1;
      default:          sel_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr.wr_valid <= 1'b0;
    end else begin
      // unknown or read-only address drops the write
      wr.wr_valid <= wr_ok && (sel_d != '0);
    end
  end

  // command payload, only looked at with wr_valid
  always_ff @(posedge clk) begin
    wr.sel  <= sel_d;
    wr.mask <= csr_w_mask_i;
    wr.data <= csr_w_data_i;
  end

  a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    wr.wr_valid |-> $onehot(wr.sel));

endmodule

// ==== rtl/csr_regfile.sv ====
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_regfile (
  input  logic               clk,
  input  logic               rst_n,
  csr_wr_if.sink             wr,
  input  csr_pkg::irq_t      int_i,
  input  logic               timer_irq_i,
  output csr_pkg::csr_data_t crmd_o,
  output csr_pkg::csr_data_t prmd_o,
  output csr_pkg::csr_data_t estat_o,
  output csr_pkg::csr_data_t era_o,
  output csr_pkg::csr_data_t eentry_o,
  output csr_pkg::csr_data_t save0_o,
  output csr_pkg::csr_data_t save1_o,
  output csr_pkg::csr_data_t save2_o,
  output csr_pkg::csr_data_t save3_o,
  output csr_pkg::csr_data_t tid_o
);
  import csr_pkg::*;

  // indexed by the select bit of each register
  localparam csr_mask_t WR_MASK [`CSR_RF_NUM] = '{
    `CSR_CRMD_WMASK,
    `CSR_PRMD_WMASK,
    `CSR_ESTAT_WMASK,
    `CSR_FULL_WMASK,
    `CSR_EENTRY_WMASK,
    `CSR_FULL_WMASK,
    `CSR_FULL_WMASK,
    `CSR_FULL_WMASK,
    `CSR_FULL_WMASK,
    `CSR_FULL_WMASK
  };

  localparam csr_data_t RST_VAL [`CSR_RF_NUM] = '{
    `CSR_CRMD_RST,
    `CSR_ZERO_RST,
    `CSR_ZERO_RST,
    `CSR_ZERO_RST,
    `CSR_ZERO_RST,
    `CSR_ZERO_RST,
    `CSR_ZERO_RST,
    `CSR_ZERO_RST,
    `CSR_ZERO_RST,
    `CSR_ZERO_RST
  };

  csr_data_t regs_q [`CSR_RF_NUM];
  irq_t      irq_q;
  csr_data_t estat;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CSR_RF_NUM; i++) begin
        regs_q[i] <= RST_VAL[i];
      end
      irq_q <= '0;
    end else begin
      // hw interrupt lines sampled every cycle
      irq_q <= int_i;
      for (int i = 0; i < `CSR_RF_NUM; i++) begin
        if (wr.wr_valid && wr.sel[i]) begin
          regs_q[i] <= csr_merge(regs_q[i], wr.data, wr.mask, WR_MASK[i]);
        end
      end
    end
  end

  // stored ESTAT holds only the sw interrupt bits
  always_comb begin
    estat                 = regs_q[`CSR_SEL_ESTAT];
    estat[`CSR_ESTAT_HWI] = irq_q;
    estat[`CSR_ESTAT_TI]  = timer_irq_i;
  end

  assign crmd_o   = regs_q[`CSR_SEL_CRMD];
  assign prmd_o   = regs_q[`CSR_SEL_PRMD];
  assign estat_o  = estat;
  assign era_o    = regs_q[`CSR_SEL_ERA];
  assign eentry_o = regs_q[`CSR_SEL_EENTRY];
  assign save0_o  = regs_q[`CSR_SEL_SAVE0];
  assign save1_o  = regs_q[`CSR_SEL_SAVE1];
  assign save2_o  = regs_q[`CSR_SEL_SAVE2];
  assign save3_o  = regs_q[`CSR_SEL_SAVE3];
  assign tid_o    = regs_q[`CSR_SEL_TID];

  // reserved fields must never pick up write data
  a_reserved_zero: assert property (@(posedge clk) disable iff (!rst_n)
    ((crmd_o & ~`CSR_CRMD_WMASK) == '0) && ((prmd_o & ~`CSR_PRMD_WMASK) == '0));

endmodule

// ==== rtl/csr_timer.sv ====
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_timer (
  input  logic               clk,
  input  logic               rst_n,
  csr_wr_if.sink             wr,
  output csr_pkg::csr_data_t tcfg_o,
  output csr_pkg::csr_data_t tval_o,
  output logic               timer_irq_o,
  output csr_pkg::cnt64_t    stable_cnt_o
);
  import csr_pkg::*;

  cnt64_t    stable_cnt_q;
  csr_data_t tcfg_q;
  csr_data_t tcfg_new;
  csr_data_t tval_q;
  logic      timer_en_q;
  logic      timer_irq_q;
  logic      tcfg_we;
  logic      ticlr_clr;
  logic      expire;

  assign tcfg_we   = wr.wr_valid && wr.sel[`CSR_SEL_TCFG];
  assign ticlr_clr = wr.wr_valid && wr.sel[`CSR_SEL_TICLR]
                     && wr.mask[`CSR_TICLR_CLR] && wr.data[`CSR_TICLR_CLR];
  assign tcfg_new  = csr_merge(tcfg_q, wr.data, wr.mask, `CSR_FULL_WMASK);
  assign expire    = timer_en_q && (tval_q == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stable_cnt_q <= '0;
    end else begin
      stable_cnt_q <= stable_cnt_q + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q     <= '0;
      tval_q     <= '0;
      timer_en_q <= 1'b0;
    end else if (tcfg_we) begin
      tcfg_q     <= tcfg_new;
      tval_q     <= {tcfg_new[`CSR_TCFG_INITVAL], 2'b00};
      timer_en_q <= tcfg_new[`CSR_TCFG_EN];
    end else if (expire) begin
      // one-shot parks at all ones
      if (tcfg_q[`CSR_TCFG_PERIODIC]) begin
        tval_q <= {tcfg_q[`CSR_TCFG_INITVAL], 2'b00};
      end else begin
        tval_q <= '1;
      end
      timer_en_q <= tcfg_q[`CSR_TCFG_PERIODIC];
    end else if (timer_en_q) begin
      tval_q <= tval_q - 32'd1;
    end
  end

  // clear wins over a same-cycle expiry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timer_irq_q <= 1'b0;
    end else if (ticlr_clr) begin
      timer_irq_q <= 1'b0;
    end else if (expire) begin
      timer_irq_q <= 1'b1;
    end
  end

  assign tcfg_o       = tcfg_q;
  assign tval_o       = tval_q;
  assign timer_irq_o  = timer_irq_q;
  assign stable_cnt_o = stable_cnt_q;

  a_tval_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    (!timer_en_q && !tcfg_we) |=> $stable(tval_q));

endmodule

// ==== rtl/csr_read_port.sv ====
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_read_port (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               m2_stall_i,
  input  csr_pkg::csr_addr_t csr_r_addr_i,
  input  csr_pkg::rdcnt_t    rdcnt_i,
  input  csr_pkg::csr_data_t crmd_i,
  input  csr_pkg::csr_data_t prmd_i,
  input  csr_pkg::csr_data_t estat_i,
  input  csr_pkg::csr_data_t era_i,
  input  csr_pkg::csr_data_t eentry_i,
  input  csr_pkg::csr_data_t save0_i,
  input  csr_pkg::csr_data_t save1_i,
  input  csr_pkg::csr_data_t save2_i,
  input  csr_pkg::csr_data_t save3_i,
  input  csr_pkg::csr_data_t tid_i,
  input  csr_pkg::csr_data_t tcfg_i,
  input  csr_pkg::csr_data_t tval_i,
  input  csr_pkg::cnt64_t    stable_cnt_i,
  output csr_pkg::csr_data_t csr_r_data_o
);
  import csr_pkg::*;

  csr_addr_t rd_key;
  csr_data_t rd_data;

  // only the low byte of the CSR number is decoded
  assign rd_key = {6'b0, csr_r_addr_i[7:0]};

  always_comb begin
    rd_data = '0;
    case (rdcnt_i)
      `RDCNT_ID:    rd_data = tid_i;
      `RDCNT_VLOW:  rd_data = stable_cnt_i[31:0];
      `RDCNT_VHIGH: rd_data = stable_cnt_i[63:32];
      default: begin
        case (rd_key)
          `CSR_ADDR_CRMD:   rd_data = crmd_i;
          `CSR_ADDR_PRMD:   rd_data = prmd_i;
          `CSR_ADDR_ESTAT:  rd_data = estat_i;
          `CSR_ADDR_ERA:    rd_data = era_i;
          `CSR_ADDR_EENTRY: rd_data = eentry_i;
          `CSR_ADDR_SAVE0:  rd_data = save0_i;
          `CSR_ADDR_SAVE1:  rd_data = save1_i;
          `CSR_ADDR_SAVE2:  rd_data = save2_i;
          `CSR_ADDR_SAVE3:  rd_data = save3_i;
          `CSR_ADDR_TID:    rd_data = tid_i;
          `CSR_ADDR_TCFG:   rd_data = tcfg_i;
          `CSR_ADDR_TVAL:   rd_data = tval_i;
          // write-only clear strobe
          `CSR_ADDR_TICLR:  rd_data = '0;
          default:          rd_data = '0;
        endcase
      end
    endcase
  end

  // hold the last result across a stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      csr_r_data_o <= '0;
    end else if (!m2_stall_i) begin
      csr_r_data_o <= rd_data;
    end
  end

endmodule

// ==== rtl/core_csr.sv ====
`timescale 1ns/100ps

module core_csr (
  input  logic               clk,
  input  logic               rst_n,
  input  csr_pkg::irq_t      int_i,
  input  logic               valid_i,
  input  logic               commit_i,
  input  logic               m2_stall_i,
  input  csr_pkg::csr_addr_t csr_r_addr_i,
  input  csr_pkg::rdcnt_t    rdcnt_i,
  input  logic               csr_we_i,
  input  csr_pkg::csr_addr_t csr_w_addr_i,
  input  csr_pkg::csr_mask_t csr_w_mask_i,
  input  csr_pkg::csr_data_t csr_w_data_i,
  output csr_pkg::csr_data_t csr_r_data_o
);
  import csr_pkg::*;

  csr_data_t crmd, prmd, estat, era, eentry;
  csr_data_t save0, save1, save2, save3, tid;
  csr_data_t tcfg, tval;
  logic      timer_irq;
  cnt64_t    stable_cnt;

  csr_wr_if u_wr_if ();

  csr_write_stage u_write_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .commit_i     (commit_i),
    .m2_stall_i   (m2_stall_i),
    .csr_we_i     (csr_we_i),
    .csr_w_addr_i (csr_w_addr_i),
    .csr_w_mask_i (csr_w_mask_i),
    .csr_w_data_i (csr_w_data_i),
    .wr           (u_wr_if.src)
  );

  csr_regfile u_regfile (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr          (u_wr_if.sink),
    .int_i       (int_i),
    .timer_irq_i (timer_irq),
    .crmd_o      (crmd),
    .prmd_o      (prmd),
    .estat_o     (estat),
    .era_o       (era),
    .eentry_o    (eentry),
    .save0_o     (save0),
    .save1_o     (save1),
    .save2_o     (save2),
    .save3_o     (save3),
    .tid_o       (tid)
  );

  csr_timer u_timer (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr           (u_wr_if.sink),
    .tcfg_o       (tcfg),
    .tval_o       (tval),
    .timer_irq_o  (timer_irq),
    .stable_cnt_o (stable_cnt)
  );

  csr_read_port u_read_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .m2_stall_i   (m2_stall_i),
    .csr_r_addr_i (csr_r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .crmd_i       (crmd),
    .prmd_i       (prmd),
    .estat_i      (estat),
    .era_i        (era),
    .eentry_i     (eentry),
    .save0_i      (save0),
    .save1_i      (save1),
    .save2_i      (save2),
    .save3_i      (save3),
    .tid_i        (tid),
    .tcfg_i       (tcfg),
    .tval_i       (tval),
    .stable_cnt_i (stable_cnt),
    .csr_r_data_o (csr_r_data_o)
  );

endmodule

// ==== test/tb_core_csr.sv ====
`timescale 1ns/100ps
`include "csr_macros.svh"

module tb_core_csr;
  import csr_pkg::*;

  logic      clk;
  logic      rst_n;
  irq_t      int_i;
  logic      valid_i;
  logic      commit_i;
  logic      m2_stall_i;
  csr_addr_t csr_r_addr_i;
  rdcnt_t    rdcnt_i;
  logic      csr_we_i;
  csr_addr_t csr_w_addr_i;
  csr_mask_t csr_w_mask_i;
  csr_data_t csr_w_data_i;
  csr_data_t csr_r_data_o;

  int        mismatches;
  int        timeouts;
  int        other_errs;
  int        reads_checked;
  csr_addr_t last_w_addr;
  csr_data_t last_low;

  core_csr u_core_csr (
    .clk          (clk),
    .rst_n        (rst_n),
    .int_i        (int_i),
    .valid_i      (valid_i),
    .commit_i     (commit_i),
    .m2_stall_i   (m2_stall_i),
    .csr_r_addr_i (csr_r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .csr_we_i     (csr_we_i),
    .csr_w_addr_i (csr_w_addr_i),
    .csr_w_mask_i (csr_w_mask_i),
    .csr_w_data_i (csr_w_data_i),
    .csr_r_data_o (csr_r_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic hold_write_off();
    valid_i  <= 1'b0;
    commit_i <= 1'b0;
    csr_we_i <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n      <= 1'b0;
    m2_stall_i <= 1'b0;
    hold_write_off();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // counter restarts from zero
    last_low = '0;
  endtask

  task automatic write_csr(input csr_addr_t addr, input csr_mask_t mask, input csr_data_t data);
    @(posedge clk);
    valid_i      <= 1'b1;
    commit_i     <= 1'b1;
    csr_we_i     <= 1'b1;
    csr_w_addr_i <= addr;
    csr_w_mask_i <= mask;
    csr_w_data_i <= data;
    last_w_addr = addr;
    // idle cycles carry an uncommitted filler write
    repeat (2) begin
      @(posedge clk);
      commit_i     <= 1'b0;
      csr_w_mask_i <= $urandom();
      csr_w_data_i <= $urandom();
    end
  endtask

  task automatic read_check(input csr_addr_t addr, input rdcnt_t sel, input csr_data_t exp);
    csr_data_t got;
    @(posedge clk);
    hold_write_off();
    csr_r_addr_i <= addr;
    rdcnt_i      <= sel;
    @(posedge clk);
    @(negedge clk);
    got = csr_r_data_o;
    reads_checked++;
    if (sel == `RDCNT_VLOW) begin
      // low counter word only has to grow
      if (got <= last_low) begin
        $display("Mismatch at %0t: counter low word %h not above %h", $time, got, last_low);
        mismatches++;
      end
      last_low = got;
    end else if (got !== exp) begin
      $display("Mismatch at %0t: addr %h rdcnt %0d read %h, expected %h",
               $time, addr, sel, got, exp);
      mismatches++;
    end
  endtask

  task automatic stall_hold(input int cycles);
    csr_data_t held;
    rdcnt_t    saved_sel;
    saved_sel = rdcnt_i;
    @(posedge clk);
    m2_stall_i   <= 1'b1;
    valid_i      <= 1'b1;
    commit_i     <= 1'b1;
    csr_we_i     <= 1'b1;
    csr_w_addr_i <= last_w_addr;
    csr_w_mask_i <= $urandom();
    csr_w_data_i <= $urandom();
    // counter read keeps changing underneath the stall
    rdcnt_i      <= `RDCNT_VLOW;
    @(negedge clk);
    held = csr_r_data_o;
    repeat (cycles) begin
      @(negedge clk);
      if (csr_r_data_o !== held) begin
        $display("Mismatch at %0t: read data %h changed under stall, held %h",
                 $time, csr_r_data_o, held);
        mismatches++;
      end
    end
    @(posedge clk);
    m2_stall_i <= 1'b0;
    hold_write_off();
    rdcnt_i    <= saved_sel;
  endtask

  task automatic wait_timer_irq(input int limit);
    int   cycles;
    logic fired;
    cycles = 0;
    fired  = 1'b0;
    @(posedge clk);
    hold_write_off();
    csr_r_addr_i <= `CSR_ADDR_ESTAT;
    rdcnt_i      <= `RDCNT_NONE;
    @(posedge clk);
    while (!fired && cycles < limit) begin
      @(negedge clk);
      if (csr_r_data_o[`CSR_ESTAT_TI]) begin
        fired = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!fired) begin
      $display("Timer interrupt bit was not set within %0d cycles (at %0t)", limit, $time);
      timeouts++;
    end
  endtask

  task automatic set_irq(input irq_t val);
    @(posedge clk);
    hold_write_off();
    int_i <= val;
    // one cycle for the sampling register
    @(posedge clk);
  endtask

  initial begin
    int          fd;
    int          seed;
    int          n;
    string       line;
    byte         cmd;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    rst_n         = 1'b0;
    int_i         = '0;
    valid_i       = 1'b0;
    commit_i      = 1'b0;
    m2_stall_i    = 1'b0;
    csr_r_addr_i  = '0;
    rdcnt_i       = '0;
    csr_we_i      = 1'b0;
    csr_w_addr_i  = '0;
    csr_w_mask_i  = '0;
    csr_w_data_i  = '0;
    mismatches    = 0;
    timeouts      = 0;
    other_errs    = 0;
    reads_checked = 0;
    last_w_addr   = '0;
    last_low      = '0;
    seed = $urandom(38964);
    apply_reset();
    fd = $fopen("test/csr_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file test/csr_stim.txt");
      other_errs++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        cmd = line.getc(0);
        n   = 0;
        f1  = '0;
        f2  = '0;
        f3  = '0;
        if (line.len() > 1) begin
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", f1, f2, f3);
        end
        if ((cmd == "W" || cmd == "R") && n != 3) begin
          $display("Stimulus line is missing fields: %s", line);
          other_errs++;
        end
        case (cmd)
          "W": write_csr(f1[13:0], f2, f3);
          "R": read_check(f1[13:0], f2[1:0], f3);
          "I": set_irq(f1[7:0]);
          "S": stall_hold(int'(f1));
          "T": wait_timer_irq(int'(f1));
          "X": apply_reset();
          "#", " ", "\n": ;
          default: begin
            $display("Unknown stimulus command in line: %s", line);
            other_errs++;
          end
        endcase
      end
      $fclose(fd);
    end
    repeat (2) @(posedge clk);
    $display("Summary: %0d reads checked, %0d mismatches, %0d timeouts, %0d other errors",
             reads_checked, mismatches, timeouts, other_errs);
    if (mismatches + timeouts + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== test/csr_stim.txt ====
# W addr mask data | R addr rdcnt expected | I irq | S stall cycles
# T timeout cycles | X reset; all fields hex, rdcnt 2 reads check growth only
R 000 0 00000008
R 001 0 00000000
R 006 0 00000000
R 030 0 00000000
R 041 0 00000000
W 030 ffffffff 12345678
R 030 0 12345678
W 030 0000ffff aaaaaaaa
R 030 0 1234aaaa
S 4
R 030 0 1234aaaa
W 001 ffffffff ffffffff
R 001 0 00000007
I a5
W 005 ffffffff ffffffff
R 005 0 00000297
R 000 2 00000000
W 041 ffffffff 00000011
T 80
R 005 0 00000a97
W 044 ffffffff 00000001
R 005 0 00000297
R 042 0 ffffffff
S 6
R 042 0 ffffffff
W 040 ffffffff 0badcafe
R 000 1 0badcafe
R 000 2 00000000
R 000 3 00000000
R 07f 0 00000000
X
R 000 0 00000008

// ==== project.f ====
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_wr_if.sv
rtl/csr_write_stage.sv
rtl/csr_regfile.sv
rtl/csr_timer.sv
rtl/csr_read_port.sv
rtl/core_csr.sv
test/tb_core_csr.sv

// ==== Makefile ====
SRCS := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_core_csr: project.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	  -f project.f --top-module tb_core_csr -o Vtb_core_csr

run: obj_dir/Vtb_core_csr
	./obj_dir/Vtb_core_csr > sim.log 2>&1; cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
